// File: flist.f
logic/rv_core_pkg.sv
logic/hazard_control.sv
logic/instr_decode.sv
logic/alu.sv
logic/reg_file.sv
logic/word_mem.sv
logic/rv_core.sv
test/core_checker.sv
test/tb_top.sv

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv_core_pkg::alu_op_t         op,
  input  logic [rv_core_pkg::xlen-1:0] a,
  input  logic [rv_core_pkg::xlen-1:0] b,
  output logic [rv_core_pkg::xlen-1:0] result
);
  import rv_core_pkg::*;

  logic less; // signed a < b

  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: result = {{(xlen-1){1'b0}}, less};
      default: result = '0; // unused encodings
    endcase
  end

endmodule

`default_nettype wire

// File: logic/hazard_control.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_control (
  input  logic [rv_core_pkg::reg_addr_w-1:0] id_rs1,
  input  logic [rv_core_pkg::reg_addr_w-1:0] id_rs2,
  input  logic [rv_core_pkg::reg_addr_w-1:0] ex_rs1,
  input  logic [rv_core_pkg::reg_addr_w-1:0] ex_rs2,
  input  logic [rv_core_pkg::reg_addr_w-1:0] ex_rd,
  input  logic [rv_core_pkg::reg_addr_w-1:0] mem_rd,
  input  logic [rv_core_pkg::reg_addr_w-1:0] wb_rd,
  input  logic                               ex_mem_read,
  input  logic                               mem_reg_write,
  input  logic                               wb_reg_write,
  input  logic                               wb_is_ecall,
  output logic                               stall,
  output logic                               freeze,
  output rv_core_pkg::fwd_sel_t              fwd_a,
  output rv_core_pkg::fwd_sel_t              fwd_b
);
  import rv_core_pkg::*;

  logic mem_hit_a; // ex/mem produces rs1 of ex
  logic mem_hit_b;
  logic wb_hit_a;  // mem/wb produces rs1 of ex
  logic wb_hit_b;

  // load in ex, consumer in id: data arrives one cycle too late for forwarding
  assign stall = ex_mem_read && (ex_rd != '0) &&
                 ((ex_rd == id_rs1) || (ex_rd == id_rs2));

  assign mem_hit_a = mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs1);
  assign mem_hit_b = mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs2);
  assign wb_hit_a  = wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs1);
  assign wb_hit_b  = wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs2);

  // younger producer wins
  assign fwd_a = mem_hit_a ? fwd_mem : (wb_hit_a ? fwd_wb : fwd_reg);
  assign fwd_b = mem_hit_b ? fwd_mem : (wb_hit_b ? fwd_wb : fwd_reg);

  // ecall in wb: everything older has retired, hold the rest
  assign freeze = wb_is_ecall;

endmodule

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  logic [rv_core_pkg::xlen-1:0]       instr,
  output logic [rv_core_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_core_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_core_pkg::reg_addr_w-1:0] rd,
  output logic [rv_core_pkg::xlen-1:0]       imm,
  output rv_core_pkg::alu_op_t               alu_op,
  output logic                               alu_src_imm,
  output logic                               mem_read,
  output logic                               mem_write,
  output logic                               reg_write,
  output logic                               mem_to_reg,
  output logic                               is_ecall
);
  import rv_core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  always_comb begin
    alu_op      = alu_add; // address calc for lw/sw
    alu_src_imm = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    reg_write   = 1'b0;
    mem_to_reg  = 1'b0;
    is_ecall    = 1'b0;
    imm         = {{(xlen-12){instr[31]}}, instr[31:20]}; // i-type
    case (opcode)
      op_reg: begin
        reg_write = 1'b1;
        case (funct3)
          f3_add_sub: alu_op = instr[30] ? alu_sub : alu_add;
          f3_slt:     alu_op = alu_slt;
          f3_xor:     alu_op = alu_xor;
          f3_or:      alu_op = alu_or;
          f3_and:     alu_op = alu_and;
          default:    reg_write = 1'b0; // shifts etc not supported
        endcase
      end
      op_imm: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        case (funct3)
          f3_add_sub: alu_op = alu_add; // no subi, bit 30 is imm
          f3_xor:     alu_op = alu_xor;
          f3_or:      alu_op = alu_or;
          f3_and:     alu_op = alu_and;
          default:    reg_write = 1'b0;
        endcase
      end
      op_load: begin
        alu_src_imm = 1'b1;
        mem_read    = (funct3 == f3_word);
        reg_write   = (funct3 == f3_word);
        mem_to_reg  = 1'b1;
      end
      op_store: begin
        alu_src_imm = 1'b1;
        mem_write   = (funct3 == f3_word);
        imm         = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]}; // s-type
      end
      op_system: is_ecall = (instr[31:7] == '0); // ebreak and csr ops ignored
      default: ; // unknown opcode stays a bubble
    endcase
  end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               we,
  input  logic [rv_core_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_core_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_core_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_core_pkg::reg_addr_w-1:0] dbg_addr,
  input  logic [rv_core_pkg::xlen-1:0]       rd_data,
  output logic [rv_core_pkg::xlen-1:0]       rs1_data,
  output logic [rv_core_pkg::xlen-1:0]       rs2_data,
  output logic [rv_core_pkg::xlen-1:0]       dbg_data
);
  import rv_core_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];
  logic            wr_live; // a real write this cycle

  assign wr_live = we && (rd != '0); // x0 never written, stays zero after reset

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[rd] <= rd_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rs1_data = (wr_live && (rd == rs1)) ? rd_data : regs[rs1];
  assign rs2_data = (wr_live && (rd == rs2)) ? rd_data : regs[rs2];
  assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter int imem_depth = 64,
  parameter int dmem_depth = 64
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               prog_we,
  input  logic [$clog2(imem_depth)-1:0]      prog_addr,
  input  logic [rv_core_pkg::xlen-1:0]       prog_data,
  input  logic [rv_core_pkg::reg_addr_w-1:0] dbg_addr,
  output logic [rv_core_pkg::xlen-1:0]       dbg_data,
  output logic                               halted
);
  import rv_core_pkg::*;

  localparam int ia_w = $clog2(imem_depth);
  localparam int da_w = $clog2(dmem_depth);

  logic                  stall;
  logic                  freeze;
  fwd_sel_t              fwd_a;
  fwd_sel_t              fwd_b;
  logic [xlen-1:0]       pc;
  logic [ia_w-1:0]       imem_addr;
  logic [xlen-1:0]       fetch_instr;
  logic [xlen-1:0]       if_id_instr;
  logic [reg_addr_w-1:0] id_rs1, id_rs2, id_rd;
  logic [xlen-1:0]       id_imm, id_rs1_data, id_rs2_data;
  alu_op_t               id_alu_op;
  logic                  id_alu_src_imm, id_mem_read, id_mem_write;
  logic                  id_reg_write, id_mem_to_reg, id_is_ecall;
  logic [reg_addr_w-1:0] ex_rs1, ex_rs2, ex_rd;
  logic [xlen-1:0]       ex_rs1_data, ex_rs2_data, ex_imm;
  alu_op_t               ex_alu_op;
  logic                  ex_alu_src_imm, ex_mem_read, ex_mem_write;
  logic                  ex_reg_write, ex_mem_to_reg, ex_is_ecall;
  logic [xlen-1:0]       ex_op_a, ex_rs2_val, ex_result;
  logic [reg_addr_w-1:0] mem_rd;
  logic [xlen-1:0]       mem_alu, mem_store_data, mem_load_data;
  logic                  mem_mem_write, mem_reg_write, mem_to_reg, mem_is_ecall;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_alu, wb_load_data, wb_data;
  logic                  wb_reg_write, wb_mem_to_reg, wb_is_ecall;

  // fetch
  assign imem_addr = reset ? prog_addr : pc[ia_w+1:2]; // loader owns imem during reset

  word_mem #(.depth(imem_depth)) i_imem (
    .clk(clk), .we(prog_we & reset), .addr(imem_addr), .wdata(prog_data), .rdata(fetch_instr)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      if_id_instr <= '0; // zero opcode decodes as a bubble
    end else if (!stall && !freeze) begin
      pc          <= pc + xlen'(4); // no control flow, always sequential
      if_id_instr <= fetch_instr;
    end
  end

  // decode
  instr_decode i_decode (
    .instr(if_id_instr), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm),
    .alu_op(id_alu_op), .alu_src_imm(id_alu_src_imm), .mem_read(id_mem_read),
    .mem_write(id_mem_write), .reg_write(id_reg_write), .mem_to_reg(id_mem_to_reg),
    .is_ecall(id_is_ecall)
  );

  reg_file i_regs (
    .clk(clk), .reset(reset), .we(wb_reg_write), .rs1(id_rs1), .rs2(id_rs2), .rd(wb_rd),
    .dbg_addr(dbg_addr), .rd_data(wb_data), .rs1_data(id_rs1_data), .rs2_data(id_rs2_data),
    .dbg_data(dbg_data)
  );

  hazard_control i_hazard (
    .id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
    .mem_rd(mem_rd), .wb_rd(wb_rd), .ex_mem_read(ex_mem_read), .mem_reg_write(mem_reg_write),
    .wb_reg_write(wb_reg_write), .wb_is_ecall(wb_is_ecall), .stall(stall), .freeze(freeze),
    .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_is_ecall  <= 1'b0;
    end else if (!freeze) begin
      ex_reg_write <= id_reg_write & ~stall; // stall turns id/ex into a bubble
      ex_mem_read  <= id_mem_read & ~stall;
      ex_mem_write <= id_mem_write & ~stall;
      ex_is_ecall  <= id_is_ecall & ~stall;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      ex_rs1         <= id_rs1;
      ex_rs2         <= id_rs2;
      ex_rd          <= id_rd;
      ex_rs1_data    <= id_rs1_data;
      ex_rs2_data    <= id_rs2_data;
      ex_imm         <= id_imm;
      ex_alu_op      <= id_alu_op;
      ex_alu_src_imm <= id_alu_src_imm;
      ex_mem_to_reg  <= id_mem_to_reg;
    end
  end

  // execute, operand forwarding
  always_comb begin
    case (fwd_a)
      fwd_mem: ex_op_a = mem_alu;
      fwd_wb:  ex_op_a = wb_data;
      default: ex_op_a = ex_rs1_data;
    endcase
    case (fwd_b)
      fwd_mem: ex_rs2_val = mem_alu;
      fwd_wb:  ex_rs2_val = wb_data;
      default: ex_rs2_val = ex_rs2_data;
    endcase
  end

  alu i_alu (
    .op(ex_alu_op), .a(ex_op_a), .b(ex_alu_src_imm ? ex_imm : ex_rs2_val), .result(ex_result)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_reg_write <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_is_ecall  <= 1'b0;
    end else if (!freeze) begin
      mem_reg_write <= ex_reg_write;
      mem_mem_write <= ex_mem_write;
      mem_is_ecall  <= ex_is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      mem_rd         <= ex_rd;
      mem_alu        <= ex_result;
      mem_store_data <= ex_rs2_val; // forwarded rs2 for sw
      mem_to_reg     <= ex_mem_to_reg;
    end
  end

  // memory, index wraps over dmem_depth words
  word_mem #(.depth(dmem_depth)) i_dmem (
    .clk(clk), .we(mem_mem_write & ~freeze), .addr(mem_alu[da_w+1:2]),
    .wdata(mem_store_data), .rdata(mem_load_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      wb_is_ecall  <= 1'b0;
      halted       <= 1'b0;
    end else begin
      if (!freeze) begin
        wb_reg_write <= mem_reg_write;
        wb_is_ecall  <= mem_is_ecall;
      end
      if (freeze) halted <= 1'b1; // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      wb_rd         <= mem_rd;
      wb_alu        <= mem_alu;
      wb_load_data  <= mem_load_data; // lw result, picked by wb_mem_to_reg
      wb_mem_to_reg <= mem_to_reg;
    end
  end

  assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu;

endmodule

`default_nettype wire

// File: logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  parameter int xlen       = 32; // data and address width
  parameter int reg_addr_w = 5;  // 32 architectural registers

  // major opcodes of the kept subset
  parameter logic [6:0] op_reg    = 7'b0110011; // add sub and or xor slt
  parameter logic [6:0] op_imm    = 7'b0010011; // addi andi ori xori
  parameter logic [6:0] op_load   = 7'b0000011; // lw
  parameter logic [6:0] op_store  = 7'b0100011; // sw
  parameter logic [6:0] op_system = 7'b1110011; // ecall

  parameter logic [2:0] f3_add_sub = 3'b000; // bit 30 of funct7 picks sub
  parameter logic [2:0] f3_slt     = 3'b010;
  parameter logic [2:0] f3_xor     = 3'b100;
  parameter logic [2:0] f3_or      = 3'b110;
  parameter logic [2:0] f3_and     = 3'b111;
  parameter logic [2:0] f3_word    = 3'b010; // lw / sw width

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_slt = 3'd5
  } alu_op_t;

  // operand source for the execute stage
  typedef enum logic [1:0] {
    fwd_reg = 2'd0, // value read in decode
    fwd_mem = 2'd1, // alu result sitting in ex/mem
    fwd_wb  = 2'd2  // writeback value
  } fwd_sel_t;

endpackage

`default_nettype wire

// File: logic/word_mem.sv
`timescale 1ns/1ps
`default_nettype none

module word_mem #(
  parameter int depth = 64
) (
  input  logic                         clk,
  input  logic                         we,
  input  logic [$clog2(depth)-1:0]     addr,
  input  logic [rv_core_pkg::xlen-1:0] wdata,
  output logic [rv_core_pkg::xlen-1:0] rdata
);
  import rv_core_pkg::*;

  logic [xlen-1:0] mem [depth]; // one word per entry

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  assign rdata = mem[addr]; // async read, same-cycle data

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# builds the core and testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_top -f flist.f -Mdir obj_dir -o sim_top
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: test/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker (
  input  logic        clk,
  input  logic        halted,
  input  logic [4:0]  dbg_addr,
  input  logic [31:0] dbg_data,
  input  logic [31:0] exp_data,    // model value for dbg_addr
  input  logic        check_en,
  input  logic        expect_run,  // halted must still be low
  input  logic        expect_halt, // halted must be high
  output int          value_errs,
  output int          status_errs
);

  int v_errs = 0;
  int s_errs = 0;

  assign value_errs  = v_errs;
  assign status_errs = s_errs;

  // inputs change on the rising edge, so values seen here are from the previous edge
  always @(posedge clk) begin
    if (check_en && (dbg_data !== exp_data)) begin
      $display("ERR dbg_data x%0d: expected %h, got %h", dbg_addr, exp_data, dbg_data);
      v_errs = v_errs + 1;
    end
    if (expect_run && (halted !== 1'b0)) begin
      $display("halted is not low right after reset");
      s_errs = s_errs + 1;
    end
    if (expect_halt && (halted !== 1'b1)) begin
      $display("halted dropped while the core should stay frozen");
      s_errs = s_errs + 1;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  logic        clk;
  logic        reset;
  logic        prog_we;
  logic [5:0]  prog_addr;
  logic [31:0] prog_data;
  logic [4:0]  dbg_addr;
  logic [31:0] dbg_data;
  logic        halted;
  logic [31:0] exp_data;     // model value for the register on dbg_addr
  logic        check_en;
  logic        expect_run;   // halted must be low
  logic        expect_halt;  // halted must be high
  int          value_errs;
  int          status_errs;
  int          timeouts;
  logic [15:0] lfsr;
  logic [4:0]  prev_rd;      // last written rd, reused to build chains
  logic [31:0] prog [64];
  logic [31:0] model_regs [32];
  logic [31:0] model_mem [64];
  logic        mem_written [64];

  rv_core #(.imem_depth(64), .dmem_depth(64)) i_dut (
    .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .dbg_addr(dbg_addr), .dbg_data(dbg_data), .halted(halted)
  );

  core_checker i_checker (
    .clk(clk), .halted(halted), .dbg_addr(dbg_addr), .dbg_data(dbg_data),
    .exp_data(exp_data), .check_en(check_en), .expect_run(expect_run),
    .expect_halt(expect_halt), .value_errs(value_errs), .status_errs(status_errs)
  );

  always #5 clk = ~clk; // 10 ns period

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
    if (rd != 5'd0) model_regs[rd] = val; // x0 stays zero
  endtask

  // sel 0..5 add sub and or xor slt, sel 6..9 addi andi ori xori
  task automatic make_alu(input int sel, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [11:0] imm, input bit run,
                          output logic [31:0] word);
    int          op;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    op = (sel < 6) ? sel : ((sel == 6) ? 0 : sel - 5);
    a  = model_regs[rs1];
    b  = (sel < 6) ? model_regs[rs2] : {{20{imm[11]}}, imm}; // sign-extended imm
    case (op)
      0:       res = a + b;
      1:       res = a - b;
      2:       res = a & b;
      3:       res = a | b;
      4:       res = a ^ b;
      default: res = {31'b0, $signed(a) < $signed(b)};
    endcase
    f3 = (op == 2) ? 3'b111 : (op == 3) ? 3'b110 : (op == 4) ? 3'b100 :
         (op == 5) ? 3'b010 : 3'b000;
    if (sel < 6) begin
      word = {((op == 1) ? 7'b0100000 : 7'b0000000), rs2, rs1, f3, rd, 7'b0110011};
    end else begin
      word = {imm, rs1, f3, rd, 7'b0010011};
    end
    if (run) write_reg(rd, res); // model runs in step with generation
  endtask

  task automatic gen_program();
    logic [31:0] cls, rd, rs1, rs2, chain, imm, sel, wrap, idx;
    logic [31:0] word;
    logic [5:0]  slot;
    for (int i = 0; i < 40; i++) begin
      take_bits(3, cls);
      take_bits(3, rd); // x0..x7 keeps dependencies dense
      take_bits(3, rs1);
      take_bits(3, rs2);
      take_bits(1, chain);
      take_bits(12, imm);
      if (chain[0]) rs1 = {27'b0, prev_rd}; // consume the previous result
      if (cls < 3) begin
        take_bits(3, sel);
        make_alu(sel % 6, rd[4:0], rs1[4:0], rs2[4:0], imm[11:0], 1'b1, word);
        prev_rd = rd[4:0];
      end else if (cls < 5) begin
        take_bits(2, sel);
        make_alu(sel + 6, rd[4:0], rs1[4:0], rs2[4:0], imm[11:0], 1'b1, word);
        prev_rd = rd[4:0];
      end else begin
        take_bits(1, wrap);
        take_bits(3, idx);
        imm  = (wrap << 8) | (idx << 2); // +256 maps onto the same word
        slot = imm[7:2];                 // dmem index wraps at 64 words
        if (cls < 7 && mem_written[slot]) begin
          word = {imm[11:0], 5'd0, 3'b010, rd[4:0], 7'b0000011}; // lw rd, imm(x0)
          write_reg(rd[4:0], model_mem[slot]);
          prev_rd = rd[4:0];
        end else begin
          word = {imm[11:5], rs1[4:0], 5'd0, 3'b010, imm[4:0], 7'b0100011}; // sw
          model_mem[slot]   = model_regs[rs1[4:0]];
          mem_written[slot] = 1'b1;
        end
      end
      prog[i] = word;
    end
    prog[40] = 32'h0000_0073; // ecall
    for (int i = 41; i < 47; i++) begin
      take_bits(3, rd);
      take_bits(3, rs1);
      take_bits(12, imm);
      take_bits(2, sel);
      make_alu(sel + 6, rd[4:0], rs1[4:0], 5'd0, imm[11:0], 1'b0, word); // must not retire
      prog[i] = word;
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < 64; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= 6'(i);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  task automatic wait_halt(output bit seen);
    seen = 1'b0;
    for (int n = 0; n < 200 && !seen; n++) begin
      @(posedge clk);
      if (halted) seen = 1'b1;
    end
  endtask

  task automatic read_regs();
    for (int r = 0; r < 32; r++) begin
      @(posedge clk);
      dbg_addr <= 5'(r);
      exp_data <= model_regs[r];
      check_en <= 1'b1;
    end
    @(posedge clk); // x31 is compared on this edge
    check_en    <= 1'b0;
    expect_halt <= 1'b0;
    @(posedge clk); // counts settled before the summary
  endtask

  initial begin
    bit halt_seen;
    clk         = 1'b0;
    reset       = 1'b1;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    dbg_addr    = '0;
    exp_data    = '0;
    check_en    = 1'b0;
    expect_run  = 1'b0;
    expect_halt = 1'b0;
    timeouts    = 0;
    lfsr        = 16'd29331;
    prev_rd     = '0;
    for (int i = 0; i < 64; i++) begin
      prog[i]        = '0; // zero word decodes as a bubble
      model_mem[i]   = '0;
      mem_written[i] = 1'b0;
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    gen_program();
    load_program();           // imem only takes writes during reset
    repeat (5) @(posedge clk);
    reset      <= 1'b0;
    expect_run <= 1'b1;
    @(posedge clk);
    expect_run <= 1'b0;
    wait_halt(halt_seen);
    if (!halt_seen) begin
      $display("halted never rose within 200 cycles after reset");
      timeouts++;
    end else begin
      expect_halt <= 1'b1;
      repeat (20) @(posedge clk); // core must stay frozen
      read_regs();
    end
    $display("errors: %0d value, %0d status, %0d timeout", value_errs, status_errs, timeouts);
    if (value_errs + status_errs + timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
